// ==== Bender.yml ====
package:
  name: lsu_load_path

sources:
  - hdl/types.sv
  - hdl/lsu_ag.sv
  - hdl/lsu_ex.sv
  - hdl/dc_tag_array.sv
  - hdl/dc_data_array.sv
  - hdl/lsu_mshq.sv
  - hdl/lsu_top.sv
  - target: test
    files:
      - bench/mem_model.sv
      - bench/lsu_tb.sv

// ==== bench/lsu_tb.sv ====
// LSU load path testbench with trace-driven loads, writeback monitor and watchdog

module lsu_tb;

    import types::*;

    localparam int PERIOD        = 4;
    localparam int MSHQ_DEPTH    = 4;
    localparam int REFILL_CYCLES = 64;
    localparam int MAX_OPS       = 256;

    logic     clk;
    logic     i_arst_n;
    logic     i_valid;
    lsu_req_t i_req;
    logic     o_wb_valid;
    lsu_wb_t  o_wb;
    logic     mem_req;
    logic [ADDR_WIDTH-1:0] mem_line_addr;
    logic     mem_valid;
    logic [DATA_WIDTH-1:0] mem_data;

    // Parsed trace
    byte       op_kind  [MAX_OPS];
    string     op_name  [MAX_OPS];
    lsu_func_t op_func  [MAX_OPS];
    logic [31:0] op_addr [MAX_OPS];
    int        op_tag   [MAX_OPS];
    logic [31:0] op_data [MAX_OPS];
    int        op_mode  [MAX_OPS];
    int        op_idle  [MAX_OPS];
    int        n_ops;
    int        n_loads;

    // Outstanding loads by tag, mode 1 must hit, 2 must miss
    bit          pend     [64];
    bit          done     [64];
    logic [31:0] pend_data[64];
    logic [31:0] pend_addr[64];
    int          pend_cyc [64];
    int          pend_mode[64];
    int          n_pending;

    int cycle;
    int errors;
    int test_errors;
    int checks;
    int tests_passed;
    int tests_failed;

    lsu_top #(.MSHQ_DEPTH(MSHQ_DEPTH)) dut (
        .clk             (clk),
        .i_arst_n        (i_arst_n),
        .i_valid         (i_valid),
        .i_req           (i_req),
        .o_wb_valid      (o_wb_valid),
        .o_wb            (o_wb),
        .o_mem_req       (mem_req),
        .o_mem_line_addr (mem_line_addr),
        .i_mem_valid     (mem_valid),
        .i_mem_data      (mem_data)
    );

    mem_model u_mem (
        .clk         (clk),
        .i_req       (mem_req),
        .i_line_addr (mem_line_addr),
        .o_valid     (mem_valid),
        .o_data      (mem_data)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            $display("MISMATCH t=%0t %s got %h expected %h", $time, name, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    task automatic report_error(input string msg);
        $display("ERROR t=%0t %s", $time, msg);
        errors++;
        test_errors++;
    endtask

    function automatic bit decode_func(input string s, output lsu_func_t f);
        decode_func = 1'b1;
        case (s)
            "LB":    f = LSU_FUNC_LB;
            "LH":    f = LSU_FUNC_LH;
            "LW":    f = LSU_FUNC_LW;
            "LBU":   f = LSU_FUNC_LBU;
            "LHU":   f = LSU_FUNC_LHU;
            default: decode_func = 1'b0;
        endcase
    endfunction

    task automatic read_trace();
        int    fd;
        int    cnt;
        string line;
        string kw;
        string fs;
        fd = $fopen("bench/lsu_trace.txt", "r");
        if (fd == 0) begin
            report_error("cannot open trace file bench/lsu_trace.txt");
            return;
        end
        while ($fgets(line, fd) != 0) begin
            cnt = $sscanf(line, "%s", kw);
            if (cnt <= 0 || kw.getc(0) == "#") continue;
            op_kind[n_ops] = kw.getc(0);
            if (kw == "T") begin
                cnt = $sscanf(line, "%s %s", kw, op_name[n_ops]);
            end else if (kw == "L") begin
                cnt = $sscanf(line, "%s %s %h %d %h %d %d", kw, fs, op_addr[n_ops],
                              op_tag[n_ops], op_data[n_ops], op_mode[n_ops], op_idle[n_ops]);
                if (cnt != 7 || !decode_func(fs, op_func[n_ops])) begin
                    report_error({"malformed load line in trace: ", line});
                    continue;
                end
                n_loads++;
            end
            n_ops++;
        end
        $fclose(fd);
    endtask

    // Waits for outstanding loads, anything left after the limit is lost
    task automatic drain();
        int waited;
        waited = 0;
        while (n_pending != 0 && waited < MSHQ_DEPTH * REFILL_CYCLES) begin
            @(negedge clk);
            waited++;
        end
        for (int t = 0; t < 64; t++) begin
            if (pend[t]) begin
                report_error($sformatf("load with tag %0d never wrote back", t));
                pend[t] = 1'b0;
            end
        end
        n_pending = 0;
    endtask

    task automatic close_test(input string name);
        drain();
        if (test_errors == 0) begin
            $display("test %s: passed", name);
            tests_passed++;
        end else begin
            $display("test %s: failed with %0d errors", name, test_errors);
            tests_failed++;
        end
        test_errors = 0;
    endtask

    task automatic issue_load(input int i);
        int t;
        t = op_tag[i];
        @(posedge clk);
        #1;
        if (pend[t]) begin
            report_error($sformatf("trace reuses tag %0d while it is pending", t));
        end
        i_valid        = 1'b1;
        i_req          = '{func: op_func[i], addr: op_addr[i], tag: t[TAG_WIDTH-1:0]};
        pend[t]        = 1'b1;
        done[t]        = 1'b0;
        pend_data[t]   = op_data[i];
        pend_addr[t]   = op_addr[i];
        pend_cyc[t]    = cycle;
        pend_mode[t]   = op_mode[i];
        n_pending++;
        // Back-to-back loads keep the strobe high
        if (op_idle[i] > 0 || i + 1 >= n_ops || op_kind[i + 1] != "L") begin
            @(posedge clk);
            #1;
            i_valid = 1'b0;
            repeat (op_idle[i] - 1) @(posedge clk);
        end
    endtask

    // Writeback monitor, sampled mid-cycle
    always @(negedge clk) begin
        int t;
        if (i_arst_n && o_wb_valid) begin
            t = o_wb.tag;
            if (!pend[t]) begin
                if (done[t]) begin
                    report_error($sformatf("duplicate writeback for tag %0d", t));
                end else begin
                    report_error($sformatf("writeback with unknown tag %0d", t));
                end
            end else begin
                check_value($sformatf("o_wb.data tag %0d", t), o_wb.data, pend_data[t]);
                check_value($sformatf("o_wb.addr tag %0d", t), o_wb.addr, pend_addr[t]);
                if (pend_mode[t] == 1) begin
                    check_value($sformatf("writeback cycle tag %0d", t), cycle, pend_cyc[t] + 1);
                end else if (pend_mode[t] == 2 && cycle <= pend_cyc[t] + 1) begin
                    report_error($sformatf("load with tag %0d hit but should have missed", t));
                end
                pend[t] = 1'b0;
                done[t] = 1'b1;
                n_pending--;
            end
        end
    end

    initial begin
        longint limit;
        wait (i_arst_n === 1'b1);
        limit = longint'(n_loads + 10) * REFILL_CYCLES * PERIOD;
        #(limit);
        $display("ERROR t=%0t watchdog expired before the trace finished", $time);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        string cur;
        i_arst_n  = 1'b0;
        i_valid   = 1'b0;
        i_req     = '0;
        cycle     = 0;
        errors    = 0;
        checks    = 0;
        n_ops     = 0;
        n_loads   = 0;
        n_pending = 0;
        cur       = "";
        read_trace();
        repeat (10) @(posedge clk);
        #1;
        i_arst_n = 1'b1;
        for (int i = 0; i < n_ops; i++) begin
            if (op_kind[i] == "T") begin
                if (cur != "") close_test(cur);
                cur = op_name[i];
            end else if (op_kind[i] == "L") begin
                issue_load(i);
            end else begin
                drain();
            end
        end
        if (cur != "") close_test(cur);
        $display("summary: %0d tests passed, %0d failed, %0d checks, %0d errors",
                 tests_passed, tests_failed, checks, errors);
        if (errors == 0 && n_ops > 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== bench/lsu_trace.txt ====
# T name | L func addr tag expected mode(0 any, 1 hit, 2 miss) idle | W drain
# Memory word at A is {A[15:0] ^ 5a5a, ~A[15:0]}
T cold_miss_same_line
L LW  00000100 1 5b5afeff 2 0
W
L LB  00000105 2 fffffffe 1 0
L LHU 0000010a 3 00005b52 1 0
L LW  0000011c 4 5b46fee3 1 0
T extension_all_offsets
L LW  00002000 5 7a5adfff 2 0
W
L LB  00002000 6 ffffffff 1 0
L LB  00002001 7 ffffffdf 1 0
L LB  00002002 8 0000005a 1 0
L LB  00002003 9 0000007a 1 0
L LBU 00002000 10 000000ff 1 0
L LBU 00002001 11 000000df 1 0
L LBU 00002002 12 0000005a 1 0
L LBU 00002003 13 0000007a 1 0
L LH  00002000 14 ffffdfff 1 0
L LH  00002002 15 00007a5a 1 0
L LHU 00002000 16 0000dfff 1 0
L LHU 00002002 17 00007a5a 1 0
T back_to_back_misses
L LW  00003040 20 6a1acfbf 2 0
L LH  00003066 21 00006a3e 2 0
L LBU 0000408b 22 0000001a 2 0
L LB  000050ad 23 ffffffaf 2 0
L LW  00002004 24 7a5edffb 1 0
W
T set_eviction
L LW  000000c0 25 5a9aff3f 2 0
W
L LW  000002c0 26 589afd3f 2 0
W
L LW  000004c0 27 5e9afb3f 2 0
W
L LW  000002c4 28 589efd3b 1 0
L LW  000000c0 29 5a9aff3f 2 0
W
T same_line_misses
L LW  00000140 30 5b1afebf 2 0
L LHU 00000156 31 00005b0e 2 0
W
T hits_during_replay
L LW  00000160 32 5b3afe9f 2 0
L LW  00002000 33 7a5adfff 1 4
L LW  00002004 34 7a5edffb 1 4
L LW  00000104 35 5b5efefb 1 4
L LW  00000108 36 5b52fef7 1 4
L LW  0000011c 37 5b46fee3 1 4
L LW  00000100 38 5b5afeff 1 4
L LH  00002002 39 00007a5a 1 4
L LB  00000105 40 fffffffe 1 4
W

// ==== bench/mem_model.sv ====
// Refill memory model with random latency, random beat gaps and address-derived data

module mem_model #(
    parameter int DC_LINE_WIDTH = 5
) (
    input  logic        clk,
    input  logic        i_req,
    input  logic [31:0] i_line_addr,
    output logic        o_valid,
    output logic [31:0] o_data
);

    localparam int BEATS = 2 ** (DC_LINE_WIDTH - 2);

    // Upper half is the address XOR 5a5a, lower half the inverted address
    function automatic logic [31:0] word_at(input logic [31:0] addr);
        return {addr[15:0] ^ 16'h5a5a, ~addr[15:0]};
    endfunction

    initial begin
        logic [31:0] line;
        int          delay;
        int          gap;
        o_valid = 1'b0;
        o_data  = '0;
        // Fixed seed for the latency and gap sequence
        void'($urandom(32'hd125ce32));
        forever begin
            @(negedge clk);
            if (i_req === 1'b1) begin
                line  = i_line_addr;
                delay = 2 + ($urandom % 8);
                repeat (delay) @(posedge clk);
                for (int b = 0; b < BEATS; b++) begin
                    @(posedge clk);
                    #1;
                    o_valid = 1'b0;
                    gap = $urandom % 3;
                    repeat (gap) begin
                        @(posedge clk);
                        #1;
                    end
                    o_valid = 1'b1;
                    o_data  = word_at(line + 32'(4 * b));
                end
                @(posedge clk);
                #1;
                o_valid = 1'b0;
            end
        end
    end

endmodule

// ==== hdl/dc_data_array.sv ====
// Data cache word storage with combinational read and synchronous refill write

module dc_data_array #(
    parameter  int DC_LINE_WIDTH  = 5,
    parameter  int DC_INDEX_WIDTH = 4,
    parameter  int DC_WAY_WIDTH   = 1,
    localparam int DC_ADDR_WIDTH  = DC_INDEX_WIDTH + DC_WAY_WIDTH + DC_LINE_WIDTH - 2
) (
    input  logic                         clk,

    // Load read, address is {index, way, word}
    input  logic [DC_ADDR_WIDTH-1:0]     i_rd_addr,
    output logic [types::DATA_WIDTH-1:0] o_rd_data,

    // Refill write from the MSHQ
    input  logic                         i_wr_en,
    input  logic [DC_ADDR_WIDTH-1:0]     i_wr_addr,
    input  logic [types::DATA_WIDTH-1:0] i_wr_data
);

    import types::*;

    localparam int NUM_WORDS = 2 ** DC_ADDR_WIDTH;

    logic [DATA_WIDTH-1:0] mem [NUM_WORDS];

    assign o_rd_data = mem[i_rd_addr];

    always_ff @(posedge clk) begin
        if (i_wr_en) begin
            mem[i_wr_addr] <= i_wr_data;
        end
    end

endmodule

// ==== hdl/dc_tag_array.sv ====
// Data cache tag and valid storage with parallel lookup, fill port and round-robin victim choice

module dc_tag_array #(
    parameter  int DC_LINE_WIDTH  = 5,
    parameter  int DC_INDEX_WIDTH = 4,
    parameter  int DC_WAY_WIDTH   = 1,
    localparam int DC_TAG_WIDTH   = types::ADDR_WIDTH - DC_INDEX_WIDTH - DC_LINE_WIDTH
) (
    input  logic                      clk,
    input  logic                      i_arst_n,

    // Lookup from the execute stage
    input  logic [DC_INDEX_WIDTH-1:0] i_index,
    input  logic [DC_TAG_WIDTH-1:0]   i_tag,
    output logic                      o_hit,
    output logic [DC_WAY_WIDTH-1:0]   o_way,

    // Fill from the MSHQ
    input  logic                      i_fill_en,
    input  logic [DC_INDEX_WIDTH-1:0] i_fill_index,
    input  logic [DC_TAG_WIDTH-1:0]   i_fill_tag,
    output logic [DC_WAY_WIDTH-1:0]   o_fill_way
);

    localparam int NUM_SETS = 2 ** DC_INDEX_WIDTH;
    localparam int NUM_WAYS = 2 ** DC_WAY_WIDTH;

    logic [DC_TAG_WIDTH-1:0] tag_q    [NUM_SETS][NUM_WAYS];
    logic [NUM_WAYS-1:0]     valid_q  [NUM_SETS];
    logic [DC_WAY_WIDTH-1:0] victim_q [NUM_SETS];
    logic                    fill_match;
    logic [DC_WAY_WIDTH-1:0] match_way;
    logic [NUM_SETS-1:0]     dup_set;

    // Returns {hit, way} for a tag in one set
    function automatic logic [DC_WAY_WIDTH:0] find_way(
        input logic [DC_INDEX_WIDTH-1:0] index,
        input logic [DC_TAG_WIDTH-1:0]   tag
    );
        logic [DC_WAY_WIDTH:0] found;
        found = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (valid_q[index][w] && tag_q[index][w] == tag) begin
                found = {1'b1, DC_WAY_WIDTH'(w)};
            end
        end
        return found;
    endfunction

    assign {o_hit, o_way}          = find_way(i_index, i_tag);
    assign {fill_match, match_way} = find_way(i_fill_index, i_fill_tag);

    // Refill of a resident line reuses its way
    assign o_fill_way = fill_match ? match_way : victim_q[i_fill_index];

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                valid_q[s]  <= '0;
                victim_q[s] <= '0;
            end
        end else if (i_fill_en) begin
            valid_q[i_fill_index][o_fill_way] <= 1'b1;
            if (!fill_match) begin
                victim_q[i_fill_index] <= victim_q[i_fill_index] + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_fill_en) begin
            tag_q[i_fill_index][o_fill_way] <= i_fill_tag;
        end
    end

    always_comb begin
        dup_set = '0;
        for (int s = 0; s < NUM_SETS; s++) begin
            for (int a = 0; a < NUM_WAYS; a++) begin
                for (int b = a + 1; b < NUM_WAYS; b++) begin
                    if (valid_q[s][a] && valid_q[s][b] && tag_q[s][a] == tag_q[s][b]) begin
                        dup_set[s] = 1'b1;
                    end
                end
            end
        end
    end

    // Repeated misses to one line must not allocate a second way
    a_no_dup_way: assert property (@(posedge clk) disable iff (!i_arst_n) dup_set == '0);

endmodule

// ==== hdl/lsu_ag.sv ====
// Address stage register for new loads and MSHQ replays

module lsu_ag (
    input  logic            clk,
    input  logic            i_arst_n,

    // New load from the core
    input  logic            i_valid,
    input  types::lsu_req_t i_req,

    // Replay offered by the MSHQ
    input  logic            i_replay_valid,
    input  types::lsu_req_t i_replay_req,
    output logic            o_replay_accept,

    // Registered request into the execute stage
    output logic            o_valid,
    output types::lsu_req_t o_req
);

    import types::*;

    lsu_req_t sel_req;

    // New loads always win, a replay only fills an otherwise idle slot
    assign o_replay_accept = i_replay_valid && !i_valid;
    assign sel_req         = i_valid ? i_req : i_replay_req;

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid || i_replay_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (i_valid || i_replay_valid) begin
            o_req <= sel_req;
        end
    end

    // MSHQ must hold its replay until this stage takes it
    a_replay_stable: assert property (
        @(posedge clk) disable iff (!i_arst_n)
        i_replay_valid && !o_replay_accept |=> i_replay_valid && $stable(i_replay_req)
    );

endmodule

// ==== hdl/lsu_ex.sv ====
// Execute stage with cache lookup, hit writeback with load extension and miss routing to MSHQ

module lsu_ex #(
    parameter  int DC_LINE_WIDTH  = 5,
    parameter  int DC_INDEX_WIDTH = 4,
    parameter  int DC_WAY_WIDTH   = 1,
    localparam int DC_TAG_WIDTH   = types::ADDR_WIDTH - DC_INDEX_WIDTH - DC_LINE_WIDTH,
    localparam int DC_ADDR_WIDTH  = DC_INDEX_WIDTH + DC_WAY_WIDTH + DC_LINE_WIDTH - 2
) (
    // Request from the address stage
    input  logic                          i_valid,
    input  types::lsu_req_t               i_req,

    // Tag lookup
    input  logic                          i_dc_hit,
    input  logic [DC_WAY_WIDTH-1:0]       i_dc_way_addr,
    output logic [DC_INDEX_WIDTH-1:0]     o_dc_index,
    output logic [DC_TAG_WIDTH-1:0]       o_dc_tag,

    // Data word read
    input  logic [types::DATA_WIDTH-1:0]  i_dc_data,
    output logic [DC_ADDR_WIDTH-1:0]      o_dc_addr,

    // Miss path
    output logic                          o_mshq_en,
    output types::lsu_req_t               o_mshq_req,

    // Hit path to writeback
    output logic                          o_wb_valid,
    output types::lsu_wb_t                o_wb
);

    import types::*;

    logic [DATA_WIDTH-1:0] shifted;
    logic [DATA_WIDTH-1:0] result;

    // Address split for the tag array
    assign o_dc_index = i_req.addr[DC_INDEX_WIDTH+DC_LINE_WIDTH-1:DC_LINE_WIDTH];
    assign o_dc_tag   = i_req.addr[ADDR_WIDTH-1:ADDR_WIDTH-DC_TAG_WIDTH];

    // Word select within the hit way
    assign o_dc_addr  = {o_dc_index, i_dc_way_addr, i_req.addr[DC_LINE_WIDTH-1:2]};

    assign o_mshq_en  = i_valid && !i_dc_hit;
    assign o_mshq_req = i_req;
    assign o_wb_valid = i_valid && i_dc_hit;

    // Bring the addressed byte or halfword down to bit 0
    assign shifted = i_dc_data >> {i_req.addr[1:0], 3'b000};

    always_comb begin
        case (i_req.func)
            LSU_FUNC_LB:  result = {{(DATA_WIDTH-8){shifted[7]}}, shifted[7:0]};
            LSU_FUNC_LH:  result = {{(DATA_WIDTH-16){shifted[15]}}, shifted[15:0]};
            LSU_FUNC_LBU: result = {{(DATA_WIDTH-8){1'b0}}, shifted[7:0]};
            LSU_FUNC_LHU: result = {{(DATA_WIDTH-16){1'b0}}, shifted[15:0]};
            default:      result = i_dc_data;
        endcase
    end

    assign o_wb = '{data: result, addr: i_req.addr, tag: i_req.tag};

    // Only legal, naturally aligned loads reach this stage
    always_comb begin
        a_load_aligned: assert final (
            !i_valid
            || i_req.func == LSU_FUNC_LB
            || i_req.func == LSU_FUNC_LBU
            || ((i_req.func == LSU_FUNC_LH || i_req.func == LSU_FUNC_LHU) && !i_req.addr[0])
            || (i_req.func == LSU_FUNC_LW && i_req.addr[1:0] == 2'b00)
        );
    end

endmodule

// ==== hdl/lsu_mshq.sv ====
// Miss queue with refill FSM, memory request, beat collection, cache fill and load replay

module lsu_mshq #(
    parameter  int DC_LINE_WIDTH  = 5,
    parameter  int DC_INDEX_WIDTH = 4,
    parameter  int DC_WAY_WIDTH   = 1,
    parameter  int MSHQ_DEPTH     = 4,
    localparam int DC_TAG_WIDTH   = types::ADDR_WIDTH - DC_INDEX_WIDTH - DC_LINE_WIDTH,
    localparam int DC_ADDR_WIDTH  = DC_INDEX_WIDTH + DC_WAY_WIDTH + DC_LINE_WIDTH - 2
) (
    input  logic                         clk,
    input  logic                         i_arst_n,

    // Enqueue from the execute stage
    input  logic                         i_en,
    input  types::lsu_req_t              i_req,

    // External memory port
    output logic                         o_mem_req,
    output logic [types::ADDR_WIDTH-1:0] o_mem_line_addr,
    input  logic                         i_mem_valid,
    input  logic [types::DATA_WIDTH-1:0] i_mem_data,

    // Tag array fill
    output logic                         o_fill_en,
    output logic [DC_INDEX_WIDTH-1:0]    o_fill_index,
    output logic [DC_TAG_WIDTH-1:0]      o_fill_tag,
    input  logic [DC_WAY_WIDTH-1:0]      i_fill_way,

    // Data array writes
    output logic                         o_dwr_en,
    output logic [DC_ADDR_WIDTH-1:0]     o_dwr_addr,
    output logic [types::DATA_WIDTH-1:0] o_dwr_data,

    // Replay into the address stage
    output logic                         o_replay_valid,
    output types::lsu_req_t              o_replay_req,
    input  logic                         i_replay_accept
);

    import types::*;

    localparam int PTR_WIDTH  = (MSHQ_DEPTH > 1) ? $clog2(MSHQ_DEPTH) : 1;
    localparam int BEAT_WIDTH = DC_LINE_WIDTH - 2;

    lsu_req_t                queue_q [MSHQ_DEPTH];
    lsu_req_t                head;
    logic [PTR_WIDTH-1:0]    head_q;
    logic [PTR_WIDTH-1:0]    tail_q;
    logic [PTR_WIDTH:0]      count_q;
    mshq_state_t             state_q;
    mshq_state_t             state_d;
    logic [BEAT_WIDTH-1:0]   beat_q;
    logic [DC_WAY_WIDTH-1:0] way_q;
    logic                    full;
    logic                    pop;
    logic                    last_beat;

    function automatic logic [PTR_WIDTH-1:0] next_ptr(input logic [PTR_WIDTH-1:0] ptr);
        return (ptr == PTR_WIDTH'(MSHQ_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign head      = queue_q[head_q];
    assign full      = count_q == (PTR_WIDTH + 1)'(MSHQ_DEPTH);
    assign pop       = (state_q == REPLAY) && i_replay_accept;
    assign last_beat = &beat_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:    if (count_q != '0) state_d = REQ;
            REQ:     state_d = FILL;
            FILL:    if (i_mem_valid && last_beat) state_d = REPLAY;
            REPLAY:  if (i_replay_accept) state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_q <= IDLE;
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
            beat_q  <= '0;
        end else begin
            state_q <= state_d;
            if (i_en) begin
                tail_q <= next_ptr(tail_q);
            end
            if (pop) begin
                head_q <= next_ptr(head_q);
            end
            case ({i_en, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
            // Wraps back to zero on the last beat of a line
            if (o_dwr_en) begin
                beat_q <= beat_q + 1'b1;
            end
        end
    end

    // Queue payload and the way chosen for the current refill
    always_ff @(posedge clk) begin
        if (i_en) begin
            queue_q[tail_q] <= i_req;
        end
        if (state_q == REQ) begin
            way_q <= i_fill_way;
        end
    end

    assign o_mem_req       = state_q == REQ;
    assign o_mem_line_addr = {head.addr[ADDR_WIDTH-1:DC_LINE_WIDTH], {DC_LINE_WIDTH{1'b0}}};

    assign o_fill_index    = head.addr[DC_INDEX_WIDTH+DC_LINE_WIDTH-1:DC_LINE_WIDTH];
    assign o_fill_tag      = head.addr[ADDR_WIDTH-1:ADDR_WIDTH-DC_TAG_WIDTH];

    // Each beat goes straight into the data array, tag follows the last one
    assign o_dwr_en        = (state_q == FILL) && i_mem_valid;
    assign o_dwr_addr      = {o_fill_index, way_q, beat_q};
    assign o_dwr_data      = i_mem_data;
    assign o_fill_en       = o_dwr_en && last_beat;

    assign o_replay_valid  = state_q == REPLAY;
    assign o_replay_req    = head;

    // Load source has to respect the queue depth
    a_no_push_full: assert property (@(posedge clk) disable iff (!i_arst_n) i_en |-> !full);

    // Memory only answers the pulse sent from REQ
    a_beat_in_fill: assert property (
        @(posedge clk) disable iff (!i_arst_n) i_mem_valid |-> state_q == FILL
    );

endmodule

// ==== hdl/lsu_top.sv ====
// LSU load path top level with address and execute stages, data cache arrays and MSHQ

module lsu_top #(
    parameter int DC_LINE_WIDTH  = 5,
    parameter int DC_INDEX_WIDTH = 4,
    parameter int DC_WAY_WIDTH   = 1,
    parameter int MSHQ_DEPTH     = 4
) (
    input  logic                         clk,
    input  logic                         i_arst_n,

    input  logic                         i_valid,
    input  types::lsu_req_t              i_req,

    output logic                         o_wb_valid,
    output types::lsu_wb_t               o_wb,

    output logic                         o_mem_req,
    output logic [types::ADDR_WIDTH-1:0] o_mem_line_addr,
    input  logic                         i_mem_valid,
    input  logic [types::DATA_WIDTH-1:0] i_mem_data
);

    import types::*;

    localparam int DC_TAG_WIDTH  = ADDR_WIDTH - DC_INDEX_WIDTH - DC_LINE_WIDTH;
    localparam int DC_ADDR_WIDTH = DC_INDEX_WIDTH + DC_WAY_WIDTH + DC_LINE_WIDTH - 2;

    logic                      ex_valid;
    lsu_req_t                  ex_req;
    logic                      dc_hit;
    logic [DC_WAY_WIDTH-1:0]   dc_way;
    logic [DC_INDEX_WIDTH-1:0] dc_index;
    logic [DC_TAG_WIDTH-1:0]   dc_tag;
    logic [DC_ADDR_WIDTH-1:0]  dc_rd_addr;
    logic [DATA_WIDTH-1:0]     dc_rd_data;
    logic                      mshq_en;
    lsu_req_t                  mshq_req;
    logic                      fill_en;
    logic [DC_INDEX_WIDTH-1:0] fill_index;
    logic [DC_TAG_WIDTH-1:0]   fill_tag;
    logic [DC_WAY_WIDTH-1:0]   fill_way;
    logic                      dwr_en;
    logic [DC_ADDR_WIDTH-1:0]  dwr_addr;
    logic [DATA_WIDTH-1:0]     dwr_data;
    logic                      replay_valid;
    lsu_req_t                  replay_req;
    logic                      replay_accept;

    lsu_ag u_ag (
        .clk             (clk),
        .i_arst_n        (i_arst_n),
        .i_valid         (i_valid),
        .i_req           (i_req),
        .i_replay_valid  (replay_valid),
        .i_replay_req    (replay_req),
        .o_replay_accept (replay_accept),
        .o_valid         (ex_valid),
        .o_req           (ex_req)
    );

    lsu_ex #(
        .DC_LINE_WIDTH  (DC_LINE_WIDTH),
        .DC_INDEX_WIDTH (DC_INDEX_WIDTH),
        .DC_WAY_WIDTH   (DC_WAY_WIDTH)
    ) u_ex (
        .i_valid       (ex_valid),
        .i_req         (ex_req),
        .i_dc_hit      (dc_hit),
        .i_dc_way_addr (dc_way),
        .o_dc_index    (dc_index),
        .o_dc_tag      (dc_tag),
        .i_dc_data     (dc_rd_data),
        .o_dc_addr     (dc_rd_addr),
        .o_mshq_en     (mshq_en),
        .o_mshq_req    (mshq_req),
        .o_wb_valid    (o_wb_valid),
        .o_wb          (o_wb)
    );

    dc_tag_array #(
        .DC_LINE_WIDTH  (DC_LINE_WIDTH),
        .DC_INDEX_WIDTH (DC_INDEX_WIDTH),
        .DC_WAY_WIDTH   (DC_WAY_WIDTH)
    ) u_tag_array (
        .clk          (clk),
        .i_arst_n     (i_arst_n),
        .i_index      (dc_index),
        .i_tag        (dc_tag),
        .o_hit        (dc_hit),
        .o_way        (dc_way),
        .i_fill_en    (fill_en),
        .i_fill_index (fill_index),
        .i_fill_tag   (fill_tag),
        .o_fill_way   (fill_way)
    );

    dc_data_array #(
        .DC_LINE_WIDTH  (DC_LINE_WIDTH),
        .DC_INDEX_WIDTH (DC_INDEX_WIDTH),
        .DC_WAY_WIDTH   (DC_WAY_WIDTH)
    ) u_data_array (
        .clk       (clk),
        .i_rd_addr (dc_rd_addr),
        .o_rd_data (dc_rd_data),
        .i_wr_en   (dwr_en),
        .i_wr_addr (dwr_addr),
        .i_wr_data (dwr_data)
    );

    lsu_mshq #(
        .DC_LINE_WIDTH  (DC_LINE_WIDTH),
        .DC_INDEX_WIDTH (DC_INDEX_WIDTH),
        .DC_WAY_WIDTH   (DC_WAY_WIDTH),
        .MSHQ_DEPTH     (MSHQ_DEPTH)
    ) u_mshq (
        .clk             (clk),
        .i_arst_n        (i_arst_n),
        .i_en            (mshq_en),
        .i_req           (mshq_req),
        .o_mem_req       (o_mem_req),
        .o_mem_line_addr (o_mem_line_addr),
        .i_mem_valid     (i_mem_valid),
        .i_mem_data      (i_mem_data),
        .o_fill_en       (fill_en),
        .o_fill_index    (fill_index),
        .o_fill_tag      (fill_tag),
        .i_fill_way      (fill_way),
        .o_dwr_en        (dwr_en),
        .o_dwr_addr      (dwr_addr),
        .o_dwr_data      (dwr_data),
        .o_replay_valid  (replay_valid),
        .o_replay_req    (replay_req),
        .i_replay_accept (replay_accept)
    );

endmodule

// ==== hdl/types.sv ====
// LSU package with width constants, load function and MSHQ state enums, request and writeback structs

package types;

    // Datapath widths shared by every stage of the load path
    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;
    localparam int TAG_WIDTH  = 6;

    // Bit 2 marks the zero-extending loads
    typedef enum logic [2:0] {
        LSU_FUNC_LB  = 3'd0,
        LSU_FUNC_LH  = 3'd1,
        LSU_FUNC_LW  = 3'd2,
        LSU_FUNC_LBU = 3'd4,
        LSU_FUNC_LHU = 3'd5
    } lsu_func_t;

    // Load request, 41 bits
    typedef struct packed {
        lsu_func_t             func;
        logic [ADDR_WIDTH-1:0] addr;
        logic [TAG_WIDTH-1:0]  tag;
    } lsu_req_t;

    // Writeback result, 70 bits
    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic [ADDR_WIDTH-1:0] addr;
        logic [TAG_WIDTH-1:0]  tag;
    } lsu_wb_t;

    // Refill sequence of the head MSHQ entry
    typedef enum logic [1:0] {
        IDLE,
        REQ,
        FILL,
        REPLAY
    } mshq_state_t;

endpackage

// ==== src.f ====
hdl/types.sv
hdl/lsu_ag.sv
hdl/lsu_ex.sv
hdl/dc_tag_array.sv
hdl/dc_data_array.sv
hdl/lsu_mshq.sv
hdl/lsu_top.sv
bench/mem_model.sv
bench/lsu_tb.sv
